// File: accel_pkg.sv
package accel_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] io_data_t;
  typedef logic [11:0] io_addr_t;
  typedef logic [13:0] len_t;
  typedef logic [7:0]  mem_addr_t;
  typedef logic [2:0]  byte_cnt_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [5:0]  prefix_len_t;

  localparam int PATTERN_COUNT = 4;
  localparam int PATTERN_LEN   = 4;

  typedef logic [PATTERN_COUNT-1:0] match_vec_t;

  // First byte of a pattern in the stream sits in bits 7:0
  localparam logic [PATTERN_COUNT-1:0][PATTERN_LEN*8-1:0] PATTERNS = {
    32'hdead_beef,
    32'h5453_4f50,
    32'h5054_5448,
    32'h2054_4547
  };

  localparam int IP_PREFIX_COUNT = 4;

  localparam logic [IP_PREFIX_COUNT-1:0][31:0] IP_PREFIXES = {
    32'hc633_6400,
    32'hac10_0000,
    32'hc0a8_0000,
    32'h0a00_0000
  };

  localparam logic [IP_PREFIX_COUNT-1:0][5:0] IP_PREFIX_LENS = {
    6'd24,
    6'd12,
    6'd16,
    6'd8
  };

  // Register offsets within an engine window
  localparam logic [3:0] REG_CTRL  = 4'h0;
  localparam logic [3:0] REG_LEN   = 4'h4;
  localparam logic [3:0] REG_ADDR  = 4'h8;
  localparam logic [3:0] REG_MATCH = 4'hc;

  localparam int CTRL_START = 0;
  localparam int CTRL_STOP  = 4;
  localparam int STAT_BUSY  = 1;
  localparam int STAT_DONE  = 8;
  localparam int STAT_MATCH = 9;

  localparam int ADDR_IP_BIT   = 9;
  localparam int ADDR_SUM_BIT  = 8;
  localparam int ADDR_ENG_LSB  = 4;
  localparam int ADDR_ENG_W    = 4;
  // Summary read has done bits from bit 0, match bits from here
  localparam int SUM_MATCH_LSB = 8;

endpackage

// File: accel_regs.sv
`timescale 1ns/1ps

module accel_regs #(
  parameter int ENGINE_COUNT = 2,
  localparam int ID_W = (ENGINE_COUNT > 1) ? $clog2(ENGINE_COUNT) : 1
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   io_en,
  input  logic                                   io_wen,
  input  logic [3:0]                             io_strb,
  input  accel_pkg::io_addr_t                    io_addr,
  input  accel_pkg::io_data_t                    io_wr_data,
  output accel_pkg::io_data_t                    io_rd_data,
  output logic                                   io_rd_valid,
  output logic                                   desc_valid,
  input  logic                                   desc_ready,
  output logic [ID_W-1:0]                        desc_engine,
  output accel_pkg::mem_addr_t                   desc_addr,
  output accel_pkg::len_t                        desc_len,
  output logic [ENGINE_COUNT-1:0]                eng_init,
  output logic [ENGINE_COUNT-1:0]                eng_stop,
  input  logic [ENGINE_COUNT-1:0]                eng_busy,
  input  logic [ENGINE_COUNT-1:0]                eng_byte_valid,
  input  logic [ENGINE_COUNT-1:0]                eng_byte_last,
  input  accel_pkg::match_vec_t [ENGINE_COUNT-1:0] eng_match,
  output accel_pkg::ip_addr_t                    ip_addr,
  output logic                                   ip_valid,
  input  logic                                   ip_match,
  input  logic                                   ip_done
);

  logic [accel_pkg::ADDR_ENG_W-1:0] eng_field;
  logic [ID_W-1:0]                  eng_id;
  logic [3:0]                       reg_off;
  logic                             eng_ok;
  logic                             is_ip;
  logic                             is_sum;
  logic                             wr_en;
  logic                             rd_en;
  logic                             eng_wr;
  logic                             start_wr;
  logic                             ip_ready;
  logic                             ip_stall;
  logic                             stall_rel;
  logic [ENGINE_COUNT-1:0]          status_done;
  logic [ENGINE_COUNT-1:0]          status_match;
  logic [ENGINE_COUNT-1:0]          eng_pending;
  accel_pkg::io_data_t              rd_mux;
  accel_pkg::len_t                  len_regs [ENGINE_COUNT];
  accel_pkg::mem_addr_t             addr_regs [ENGINE_COUNT];

  assign eng_field = io_addr[accel_pkg::ADDR_ENG_LSB +: accel_pkg::ADDR_ENG_W];
  assign eng_id    = eng_field[ID_W-1:0];
  assign eng_ok    = eng_field < ENGINE_COUNT;
  assign reg_off   = {io_addr[3:2], 2'b00};
  assign is_ip     = io_addr[accel_pkg::ADDR_IP_BIT];
  assign is_sum    = io_addr[accel_pkg::ADDR_SUM_BIT];
  assign wr_en     = io_en && io_wen;
  assign rd_en     = io_en && !io_wen;
  assign eng_wr    = wr_en && !is_ip && !is_sum && eng_ok && io_strb[0];
  assign start_wr  = eng_wr && reg_off == accel_pkg::REG_CTRL
                     && io_wr_data[accel_pkg::CTRL_START];

  // A check launched last cycle still shows the old done
  assign ip_ready  = ip_done && !ip_valid;
  assign stall_rel = ip_stall && ip_ready;

  for (genvar e = 0; e < ENGINE_COUNT; e++) begin : g_status
    assign status_match[e] = |eng_match[e];
    assign eng_pending[e]  = desc_valid && desc_engine == ID_W'(e);
  end

  always_comb begin
    rd_mux = '0;
    if (is_ip) begin
      rd_mux[0] = ip_match;
    end else if (is_sum) begin
      rd_mux[ENGINE_COUNT-1:0] = status_done;
      rd_mux[accel_pkg::SUM_MATCH_LSB +: ENGINE_COUNT] = status_match;
    end else if (eng_ok) begin
      case (reg_off)
        accel_pkg::REG_CTRL: begin
          rd_mux[accel_pkg::STAT_BUSY]  = eng_busy[eng_id] || eng_pending[eng_id];
          rd_mux[accel_pkg::STAT_DONE]  = status_done[eng_id];
          rd_mux[accel_pkg::STAT_MATCH] = status_match[eng_id];
        end
        accel_pkg::REG_LEN:  rd_mux = accel_pkg::io_data_t'(len_regs[eng_id]);
        accel_pkg::REG_ADDR: rd_mux = accel_pkg::io_data_t'(addr_regs[eng_id]);
        default:             rd_mux = accel_pkg::io_data_t'(eng_match[eng_id]);
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      desc_valid  <= 1'b0;
      eng_init    <= '0;
      eng_stop    <= '0;
      ip_valid    <= 1'b0;
      ip_stall    <= 1'b0;
      io_rd_valid <= 1'b0;
      status_done <= '0;
    end else begin
      eng_init    <= '0;
      eng_stop    <= '0;
      ip_valid    <= wr_en && is_ip;
      io_rd_valid <= (rd_en && (!is_ip || ip_ready)) || stall_rel;
      if (start_wr) begin
        desc_valid <= 1'b1;
      end else if (desc_ready) begin
        desc_valid <= 1'b0;
      end
      if (eng_wr && reg_off == accel_pkg::REG_CTRL) begin
        eng_init[eng_id] <= io_wr_data[accel_pkg::CTRL_START];
        eng_stop[eng_id] <= io_wr_data[accel_pkg::CTRL_STOP];
      end
      status_done <= (status_done | (eng_byte_valid & eng_byte_last) | eng_stop) & ~eng_init;
      if (rd_en && is_ip && !ip_ready) begin
        ip_stall <= 1'b1;
      end else if (stall_rel) begin
        ip_stall <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_wr) begin
      desc_engine <= eng_id;
      desc_addr   <= addr_regs[eng_id];
      desc_len    <= len_regs[eng_id];
    end
    if (eng_wr && reg_off == accel_pkg::REG_LEN) begin
      len_regs[eng_id] <= accel_pkg::len_t'(io_wr_data);
    end
    if (eng_wr && reg_off == accel_pkg::REG_ADDR) begin
      addr_regs[eng_id] <= accel_pkg::mem_addr_t'(io_wr_data);
    end
    if (wr_en && is_ip) begin
      ip_addr <= io_wr_data;
    end
    if (stall_rel) begin
      io_rd_data <= accel_pkg::io_data_t'(ip_match);
    end else if (rd_en) begin
      io_rd_data <= rd_mux;
    end
  end

  // Pending descriptor stays put unless a new start replaces it
  a_desc_hold: assert property (@(posedge clk) disable iff (rst)
    desc_valid && !desc_ready && !start_wr |=>
      desc_valid && $stable(desc_engine) && $stable(desc_addr) && $stable(desc_len));

  a_rd_single: assert property (@(posedge clk) disable iff (rst)
    io_rd_valid |=> !io_rd_valid || $past(rd_en || stall_rel));

endmodule

// File: accel_wrap.sv
`timescale 1ns/1ps

module accel_wrap #(
  parameter int ENGINE_COUNT = 2,
  localparam int ID_W = (ENGINE_COUNT > 1) ? $clog2(ENGINE_COUNT) : 1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 io_en,
  input  logic                 io_wen,
  input  logic [3:0]           io_strb,
  input  accel_pkg::io_addr_t  io_addr,
  input  accel_pkg::io_data_t  io_wr_data,
  output accel_pkg::io_data_t  io_rd_data,
  output logic                 io_rd_valid,
  output logic                 mem_rd_en,
  output accel_pkg::mem_addr_t mem_rd_addr,
  input  accel_pkg::word_t     mem_rd_data
);

  logic                                     desc_valid;
  logic                                     desc_ready;
  logic [ID_W-1:0]                          desc_engine;
  accel_pkg::mem_addr_t                     desc_addr;
  accel_pkg::len_t                          desc_len;
  logic [ENGINE_COUNT-1:0]                  eng_init;
  logic [ENGINE_COUNT-1:0]                  eng_stop;
  logic [ENGINE_COUNT-1:0]                  eng_busy;
  accel_pkg::word_t [ENGINE_COUNT-1:0]      eng_data;
  accel_pkg::byte_cnt_t [ENGINE_COUNT-1:0]  eng_cnt;
  logic [ENGINE_COUNT-1:0]                  eng_last;
  logic [ENGINE_COUNT-1:0]                  eng_valid;
  logic [ENGINE_COUNT-1:0]                  eng_ready;
  logic [ENGINE_COUNT-1:0][7:0]             eng_byte_data;
  logic [ENGINE_COUNT-1:0]                  eng_byte_valid;
  logic [ENGINE_COUNT-1:0]                  eng_byte_last;
  accel_pkg::match_vec_t [ENGINE_COUNT-1:0] eng_match;
  accel_pkg::ip_addr_t                      ip_addr;
  logic                                     ip_valid;
  logic                                     ip_match;
  logic                                     ip_done;

  // Port names line up with the nets above
  accel_regs #(
    .ENGINE_COUNT(ENGINE_COUNT)
  ) regs_i (.*);

  pkt_rd_dma #(
    .ENGINE_COUNT(ENGINE_COUNT)
  ) dma_i (.*);

  for (genvar e = 0; e < ENGINE_COUNT; e++) begin : g_engine
    byte_serializer ser_i (
      .clk        (clk),
      .rst        (rst),
      .word_data  (eng_data[e]),
      .word_cnt   (eng_cnt[e]),
      .word_last  (eng_last[e]),
      .word_valid (eng_valid[e]),
      .word_ready (eng_ready[e]),
      .byte_data  (eng_byte_data[e]),
      .byte_valid (eng_byte_valid[e]),
      .byte_last  (eng_byte_last[e])
    );

    pattern_matcher match_i (
      .clk        (clk),
      .rst        (rst),
      .init       (eng_init[e]),
      .byte_data  (eng_byte_data[e]),
      .byte_valid (eng_byte_valid[e]),
      .match      (eng_match[e])
    );
  end

  ip_prefix_check ip_check_i (
    .clk   (clk),
    .rst   (rst),
    .addr  (ip_addr),
    .valid (ip_valid),
    .match (ip_match),
    .done  (ip_done)
  );

endmodule

// File: byte_serializer.sv
`timescale 1ns/1ps

module byte_serializer (
  input  logic                 clk,
  input  logic                 rst,
  input  accel_pkg::word_t     word_data,
  input  accel_pkg::byte_cnt_t word_cnt,
  input  logic                 word_last,
  input  logic                 word_valid,
  output logic                 word_ready,
  output logic [7:0]           byte_data,
  output logic                 byte_valid,
  output logic                 byte_last
);

  accel_pkg::word_t     word_q;
  accel_pkg::byte_cnt_t cnt_q;
  logic                 last_q;
  logic                 full;
  logic [1:0]           idx;
  logic                 final_byte;

  assign final_byte = ({1'b0, idx} + 3'd1) == cnt_q;

  // Next word can load on the cycle the last byte leaves
  assign word_ready = !full || final_byte;
  assign byte_valid = full;
  assign byte_data  = word_q[idx*8 +: 8];
  assign byte_last  = full && last_q && final_byte;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
      idx  <= '0;
    end else if (word_valid && word_ready) begin
      full <= 1'b1;
      idx  <= '0;
    end else if (full) begin
      idx <= idx + 1'b1;
      if (final_byte) begin
        full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (word_valid && word_ready) begin
      word_q <= word_data;
      cnt_q  <= word_cnt;
      last_q <= word_last;
    end
  end

endmodule

// File: ip_prefix_check.sv
`timescale 1ns/1ps

module ip_prefix_check (
  input  logic                clk,
  input  logic                rst,
  input  accel_pkg::ip_addr_t addr,
  input  logic                valid,
  output logic                match,
  output logic                done
);

  localparam int IDX_W = $clog2(accel_pkg::IP_PREFIX_COUNT);

  accel_pkg::ip_addr_t    addr_q;
  accel_pkg::ip_addr_t    mask;
  accel_pkg::prefix_len_t shift;
  logic [IDX_W-1:0]       idx;
  logic                   active;
  logic                   tail;
  logic                   hit;

  assign shift = 6'd32 - accel_pkg::IP_PREFIX_LENS[idx];
  assign mask  = ~accel_pkg::ip_addr_t'(0) << shift;
  assign hit   = ((addr_q ^ accel_pkg::IP_PREFIXES[idx]) & mask) == '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      tail   <= 1'b0;
      idx    <= '0;
      match  <= 1'b0;
      done   <= 1'b0;
    end else if (valid) begin
      active <= 1'b1;
      tail   <= 1'b0;
      idx    <= '0;
      match  <= 1'b0;
      done   <= 1'b0;
    end else if (active) begin
      // One table entry per cycle
      if (hit) begin
        match <= 1'b1;
      end
      idx <= idx + 1'b1;
      if (idx == IDX_W'(accel_pkg::IP_PREFIX_COUNT - 1)) begin
        active <= 1'b0;
        tail   <= 1'b1;
      end
    end else if (tail) begin
      tail <= 1'b0;
      done <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (valid) begin
      addr_q <= addr;
    end
  end

endmodule

// File: pattern_matcher.sv
`timescale 1ns/1ps

module pattern_matcher (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  init,
  input  logic [7:0]            byte_data,
  input  logic                  byte_valid,
  output accel_pkg::match_vec_t match
);

  localparam int WIN_W  = accel_pkg::PATTERN_LEN * 8;
  localparam int HIST_W = WIN_W - 8;
  localparam int SEEN_W = $clog2(accel_pkg::PATTERN_LEN);

  logic [HIST_W-1:0]     hist;
  logic [SEEN_W-1:0]     seen;
  logic [WIN_W-1:0]      window;
  logic                  full_window;
  accel_pkg::match_vec_t hit;

  // Oldest byte lowest, like the pattern table
  assign window      = {byte_data, hist};
  assign full_window = seen == SEEN_W'(accel_pkg::PATTERN_LEN - 1);

  always_comb begin
    for (int k = 0; k < accel_pkg::PATTERN_COUNT; k++) begin
      hit[k] = window == accel_pkg::PATTERNS[k];
    end
  end

  always_ff @(posedge clk) begin
    if (rst || init) begin
      hist  <= '0;
      seen  <= '0;
      match <= '0;
    end else if (byte_valid) begin
      hist <= window[WIN_W-1:8];
      // Compare only once the window holds bytes of this job alone
      if (full_window) begin
        match <= match | hit;
      end else begin
        seen <= seen + 1'b1;
      end
    end
  end

endmodule

// File: pkt_rd_dma.sv
`timescale 1ns/1ps

module pkt_rd_dma #(
  parameter int ENGINE_COUNT = 2,
  localparam int ID_W = (ENGINE_COUNT > 1) ? $clog2(ENGINE_COUNT) : 1
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   desc_valid,
  output logic                                   desc_ready,
  input  logic [ID_W-1:0]                        desc_engine,
  input  accel_pkg::mem_addr_t                   desc_addr,
  input  accel_pkg::len_t                        desc_len,
  output logic [ENGINE_COUNT-1:0]                eng_busy,
  input  logic [ENGINE_COUNT-1:0]                eng_stop,
  output logic                                   mem_rd_en,
  output accel_pkg::mem_addr_t                   mem_rd_addr,
  input  accel_pkg::word_t                       mem_rd_data,
  output accel_pkg::word_t [ENGINE_COUNT-1:0]    eng_data,
  output accel_pkg::byte_cnt_t [ENGINE_COUNT-1:0] eng_cnt,
  output logic [ENGINE_COUNT-1:0]                eng_last,
  output logic [ENGINE_COUNT-1:0]                eng_valid,
  input  logic [ENGINE_COUNT-1:0]                eng_ready
);

  localparam int WORD_BYTES = $bits(accel_pkg::word_t) / 8;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_WAIT_DATA,
    ST_SEND
  } state_t;

  state_t                  state;
  logic [ID_W-1:0]         eng_q;
  accel_pkg::mem_addr_t    addr_q;
  accel_pkg::len_t         left_q;
  accel_pkg::word_t        word_q;
  accel_pkg::byte_cnt_t    cnt;
  logic [ENGINE_COUNT-1:0] eng_sel;
  logic                    last_word;
  logic                    stop_hit;
  logic                    handoff;

  always_comb begin
    eng_sel        = '0;
    eng_sel[eng_q] = 1'b1;
  end

  assign last_word = left_q <= accel_pkg::len_t'(WORD_BYTES);
  assign cnt       = last_word ? accel_pkg::byte_cnt_t'(left_q)
                               : accel_pkg::byte_cnt_t'(WORD_BYTES);
  assign stop_hit  = |(eng_stop & eng_sel);
  assign handoff   = state == ST_SEND && |(eng_ready & eng_sel);

  assign desc_ready  = state == ST_IDLE;
  assign mem_rd_en   = state == ST_FETCH;
  assign mem_rd_addr = addr_q;
  assign eng_busy    = (state != ST_IDLE) ? eng_sel : '0;
  assign eng_valid   = (state == ST_SEND) ? eng_sel : '0;
  // Payload fans out to all streams and eng_valid picks the engine
  assign eng_data    = {ENGINE_COUNT{word_q}};
  assign eng_cnt     = {ENGINE_COUNT{cnt}};
  assign eng_last    = {ENGINE_COUNT{last_word}};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else if (state != ST_IDLE && stop_hit) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:      if (desc_valid && desc_len != '0) state <= ST_FETCH;
        ST_FETCH:     state <= ST_WAIT_DATA;
        ST_WAIT_DATA: state <= ST_SEND;
        ST_SEND:      if (handoff) state <= last_word ? ST_IDLE : ST_FETCH;
        default:      state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && desc_valid) begin
      eng_q  <= desc_engine;
      addr_q <= desc_addr;
      left_q <= desc_len;
    end
    if (state == ST_WAIT_DATA) begin
      word_q <= mem_rd_data;
    end
    if (handoff) begin
      addr_q <= addr_q + 1'b1;
      left_q <= left_q - accel_pkg::len_t'(WORD_BYTES);
    end
  end

  // A word offered to an engine holds until that engine takes it
  a_stream_hold: assert property (@(posedge clk) disable iff (rst)
    |eng_valid && !(|(eng_valid & eng_ready)) && !stop_hit |=>
      eng_valid == $past(eng_valid) && $stable(eng_data) && $stable(eng_cnt)
      && $stable(eng_last));

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_accel_wrap \
  -f verilog.f -o sim_accel &&
./obj_dir/sim_accel | tee /dev/stderr | grep -q -F "*** TEST PASSED ***" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tb_accel_wrap.sv
`timescale 1ns/1ps

module tb_accel_wrap;

  localparam int ENGINE_COUNT = 2;
  localparam int REG_TESTS    = 8;
  localparam int NUM_JOBS     = 24;
  localparam int NUM_PAIRS    = 4;
  localparam int NUM_IP       = 8;
  localparam int MAX_LEN      = 40;
  localparam int REGION_WORDS = 256 / ENGINE_COUNT;
  localparam int TEST_COUNT   = REG_TESTS + NUM_JOBS + 2 * NUM_PAIRS + NUM_IP + ENGINE_COUNT;
  localparam int WATCHDOG_NS  = TEST_COUNT * (MAX_LEN + 40) * 4;

  localparam accel_pkg::io_addr_t SUM_ADDR = accel_pkg::io_addr_t'(1 << accel_pkg::ADDR_SUM_BIT);
  localparam accel_pkg::io_addr_t IP_ADDR  = accel_pkg::io_addr_t'(1 << accel_pkg::ADDR_IP_BIT);

  logic                 clk;
  logic                 rst;
  logic                 io_en;
  logic                 io_wen;
  logic [3:0]           io_strb;
  accel_pkg::io_addr_t  io_addr;
  accel_pkg::io_data_t  io_wr_data;
  accel_pkg::io_data_t  io_rd_data;
  logic                 io_rd_valid;
  logic                 mem_rd_en;
  accel_pkg::mem_addr_t mem_rd_addr;
  accel_pkg::word_t     mem_rd_data;

  accel_pkg::word_t      mem_model [256];
  logic                  mem_pend;
  accel_pkg::mem_addr_t  mem_pend_addr;
  logic [31:0]           lcg_state = 32'd52;
  accel_pkg::match_vec_t exp_vec [ENGINE_COUNT];
  logic                  exp_done [ENGINE_COUNT];

  accel_wrap #(
    .ENGINE_COUNT(ENGINE_COUNT)
  ) accel_wrap_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Memory model, data one cycle after the read request
  always @(negedge clk) begin
    mem_pend      <= mem_rd_en;
    mem_pend_addr <= mem_rd_addr;
  end

  always @(posedge clk) begin
    #1;
    if (mem_pend) begin
      mem_rd_data = mem_model[mem_pend_addr];
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(int n);
    return int'(next_rand() >> 8) % n;
  endfunction

  function automatic logic [7:0] mem_byte(accel_pkg::mem_addr_t base, int j);
    accel_pkg::word_t w;
    w = mem_model[(int'(base) + j / 4) % 256];
    return w[(j % 4) * 8 +: 8];
  endfunction

  task automatic put_byte(accel_pkg::mem_addr_t base, int j, logic [7:0] b);
    mem_model[(int'(base) + j / 4) % 256][(j % 4) * 8 +: 8] = b;
  endtask

  // Reference scan, byte 0 of the job is the oldest in the window
  function automatic accel_pkg::match_vec_t model_matches(accel_pkg::mem_addr_t base, int len);
    accel_pkg::match_vec_t vec;
    logic [31:0]           window;
    vec = '0;
    for (int j = 0; j + accel_pkg::PATTERN_LEN <= len; j++) begin
      for (int i = 0; i < accel_pkg::PATTERN_LEN; i++) begin
        window[i * 8 +: 8] = mem_byte(base, j + i);
      end
      for (int k = 0; k < accel_pkg::PATTERN_COUNT; k++) begin
        if (window == accel_pkg::PATTERNS[k]) begin
          vec[k] = 1'b1;
        end
      end
    end
    return vec;
  endfunction

  function automatic logic model_ip(accel_pkg::ip_addr_t a);
    int   sh;
    logic hit;
    hit = 1'b0;
    for (int k = 0; k < accel_pkg::IP_PREFIX_COUNT; k++) begin
      sh = 32 - int'(accel_pkg::IP_PREFIX_LENS[k]);
      if ((a >> sh) == (accel_pkg::IP_PREFIXES[k] >> sh)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  function automatic accel_pkg::io_addr_t eng_reg(int e, logic [3:0] off);
    return accel_pkg::io_addr_t'(e << accel_pkg::ADDR_ENG_LSB) | accel_pkg::io_addr_t'(off);
  endfunction

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_io(string name, accel_pkg::io_data_t exp, accel_pkg::io_data_t act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_match(string name, accel_pkg::match_vec_t exp,
                             accel_pkg::match_vec_t act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic bus_write(accel_pkg::io_addr_t addr, accel_pkg::io_data_t data);
    @(posedge clk);
    #1;
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_addr    = addr;
    io_wr_data = data;
    @(posedge clk);
    #1;
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  task automatic bus_read(accel_pkg::io_addr_t addr, output accel_pkg::io_data_t data);
    @(posedge clk);
    #1;
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = addr;
    @(posedge clk);
    #1;
    io_en = 1'b0;
    // IP reads may stall here until the check is done
    while (io_rd_valid !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    data = io_rd_data;
  endtask

  task automatic start_job(int e, int len);
    accel_pkg::mem_addr_t base;
    accel_pkg::io_data_t  rd;
    int                   off;
    int                   k;
    base = accel_pkg::mem_addr_t'(e * REGION_WORDS + rand_below(REGION_WORDS - MAX_LEN / 4));
    if (len >= accel_pkg::PATTERN_LEN && rand_below(3) != 0) begin
      k   = rand_below(accel_pkg::PATTERN_COUNT);
      off = rand_below(len - accel_pkg::PATTERN_LEN + 1);
      if (rand_below(2) == 0) begin
        off = off - off % 4;
      end
      for (int i = 0; i < accel_pkg::PATTERN_LEN; i++) begin
        put_byte(base, off + i, accel_pkg::PATTERNS[k][i * 8 +: 8]);
      end
    end
    exp_vec[e]  = model_matches(base, len);
    exp_done[e] = 1'b0;
    bus_write(eng_reg(e, accel_pkg::REG_LEN), accel_pkg::io_data_t'(len));
    bus_write(eng_reg(e, accel_pkg::REG_ADDR), accel_pkg::io_data_t'(base));
    bus_write(eng_reg(e, accel_pkg::REG_CTRL), 32'h1);
    bus_read(eng_reg(e, accel_pkg::REG_CTRL), rd);
    check_bit($sformatf("engine %0d busy after start", e), 1'b1, rd[accel_pkg::STAT_BUSY]);
    check_bit($sformatf("engine %0d done cleared", e), 1'b0, rd[accel_pkg::STAT_DONE]);
    check_bit($sformatf("engine %0d match cleared", e), 1'b0, rd[accel_pkg::STAT_MATCH]);
  endtask

  task automatic finish_job(int e);
    accel_pkg::io_data_t rd;
    rd = '0;
    while (rd[accel_pkg::STAT_DONE] !== 1'b1) begin
      bus_read(eng_reg(e, accel_pkg::REG_CTRL), rd);
    end
    exp_done[e] = 1'b1;
    check_bit($sformatf("engine %0d busy at done", e), 1'b0, rd[accel_pkg::STAT_BUSY]);
    check_bit($sformatf("engine %0d ctrl match bit", e), |exp_vec[e], rd[accel_pkg::STAT_MATCH]);
    bus_read(eng_reg(e, accel_pkg::REG_MATCH), rd);
    check_match($sformatf("engine %0d match vector", e), exp_vec[e],
                accel_pkg::match_vec_t'(rd));
  endtask

  task automatic check_summary();
    accel_pkg::io_data_t rd;
    accel_pkg::io_data_t exp;
    exp = '0;
    for (int e = 0; e < ENGINE_COUNT; e++) begin
      exp[e] = exp_done[e];
      exp[accel_pkg::SUM_MATCH_LSB + e] = |exp_vec[e];
    end
    bus_read(SUM_ADDR, rd);
    check_io("status summary", exp, rd);
  endtask

  initial begin
    #(WATCHDOG_NS);
    report_failure($sformatf("timeout: tests did not finish within %0d ns", WATCHDOG_NS));
  end

  initial begin
    accel_pkg::io_data_t  rd;
    accel_pkg::io_data_t  len_v;
    accel_pkg::io_data_t  addr_v;
    accel_pkg::ip_addr_t  ip_v;
    int                   e;
    int                   b;
    int                   k;
    rst         = 1'b1;
    io_en       = 1'b0;
    io_wen      = 1'b0;
    io_strb     = 4'hf;
    io_addr     = '0;
    io_wr_data  = '0;
    mem_rd_data = '0;
    mem_pend    = 1'b0;
    for (int a = 0; a < 256; a++) begin
      mem_model[a] = next_rand();
    end
    for (int i = 0; i < ENGINE_COUNT; i++) begin
      exp_vec[i]  = '0;
      exp_done[i] = 1'b0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // Stop on an idle engine
    for (int i = 0; i < ENGINE_COUNT; i++) begin
      bus_write(eng_reg(i, accel_pkg::REG_CTRL), 32'h1 << accel_pkg::CTRL_STOP);
      exp_done[i] = 1'b1;
      bus_read(eng_reg(i, accel_pkg::REG_CTRL), rd);
      check_bit($sformatf("engine %0d done after stop", i), 1'b1, rd[accel_pkg::STAT_DONE]);
      check_bit($sformatf("engine %0d match after stop", i), 1'b0, rd[accel_pkg::STAT_MATCH]);
      bus_read(eng_reg(i, accel_pkg::REG_MATCH), rd);
      check_match($sformatf("engine %0d vector after stop", i), '0, accel_pkg::match_vec_t'(rd));
    end
    check_summary();

    for (int t = 0; t < REG_TESTS; t++) begin
      e      = rand_below(ENGINE_COUNT);
      len_v  = next_rand();
      addr_v = next_rand();
      bus_write(eng_reg(e, accel_pkg::REG_LEN), len_v);
      bus_write(eng_reg(e, accel_pkg::REG_ADDR), addr_v);
      bus_read(eng_reg(e, accel_pkg::REG_LEN), rd);
      check_io("len readback", accel_pkg::io_data_t'(accel_pkg::len_t'(len_v)), rd);
      bus_read(eng_reg(e, accel_pkg::REG_ADDR), rd);
      check_io("addr readback", accel_pkg::io_data_t'(accel_pkg::mem_addr_t'(addr_v)), rd);
    end

    for (int t = 0; t < NUM_JOBS; t++) begin
      e = rand_below(ENGINE_COUNT);
      start_job(e, 1 + rand_below(MAX_LEN));
      finish_job(e);
    end

    // Second start waits behind a long first job
    for (int t = 0; t < NUM_PAIRS; t++) begin
      e = rand_below(ENGINE_COUNT);
      b = (e + 1) % ENGINE_COUNT;
      start_job(e, 24 + rand_below(MAX_LEN - 23));
      start_job(b, 1 + rand_below(MAX_LEN));
      finish_job(e);
      finish_job(b);
      check_summary();
    end

    for (int t = 0; t < NUM_IP; t++) begin
      ip_v = next_rand();
      if (rand_below(2) == 0) begin
        k    = rand_below(accel_pkg::IP_PREFIX_COUNT);
        ip_v = accel_pkg::IP_PREFIXES[k] | (ip_v >> accel_pkg::IP_PREFIX_LENS[k]);
      end
      bus_write(IP_ADDR, ip_v);
      bus_read(IP_ADDR, rd);
      check_io("ip check stalled read", accel_pkg::io_data_t'(model_ip(ip_v)), rd);
      bus_read(IP_ADDR, rd);
      check_io("ip check held read", accel_pkg::io_data_t'(model_ip(ip_v)), rd);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: verilog.f
accel_pkg.sv
accel_regs.sv
pkt_rd_dma.sv
byte_serializer.sv
pattern_matcher.sv
ip_prefix_check.sv
accel_wrap.sv
tb_accel_wrap.sv
